// File: Bender.yml
package:
  name: rtlinf_kernel

sources:
  - files:
      - kernel_pkg.sv
      - kernel_if.sv
      - mem_reader.sv
      - distribute_in.sv
      - mac_lane.sv
      - result_writer.sv
      - rtlinf_kernel.sv
  - target: test
    files:
      - tb_kernel.sv

// File: distribute_in.sv
//////////////////////////////
// broadcast of activations to all lanes
// one weight word per iteration, taken at read index 0
// lanes may accept in different cycles
//////////////////////////////
`default_nettype none

module distribute_in import kernel_pkg::*; #(
  parameter int NUM_LANES = kernel_pkg::NUM_LANES
) (
  input  wire logic         clk,
  input  wire logic         arst_n,
  input  wire logic         configure,
  input  wire iter_t        num_iters,
  input  wire reads_t       num_reads_per_iter,
  input  wire logic         act_valid,
  output logic              act_ready,
  input  wire group_t       act_data,
  input  wire logic         w_valid,
  output logic              w_ready,
  input  wire weight_word_t w_data,
  op_if.src                 lane [NUM_LANES]
);

  iter_t        n_iters_q, iter_q;
  reads_t       n_reads_q;
  idx_t         idx_q;
  logic         w_held;       // weight of the current iteration is in w_q
  weight_word_t w_q;

  logic         bc_valid;
  group_t       bc_act;
  weight_word_t bc_w;
  idx_t         bc_idx;
  logic         bc_first, bc_last;

  logic [NUM_LANES-1:0] done, lane_rdy, lane_fire, done_nxt;
  logic                 bc_clear, act_fire, w_fire, last_read;

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    assign lane[l].valid      = bc_valid & ~done[l];
    assign lane[l].act        = bc_act;
    assign lane[l].weight     = bc_w[l];
    assign lane[l].idx        = bc_idx;
    assign lane[l].first_iter = bc_first;
    assign lane[l].last_iter  = bc_last;
    assign lane_rdy[l]        = lane[l].ready;
  end

  assign lane_fire = lane_rdy & ~done & {NUM_LANES{bc_valid}};
  assign done_nxt  = done | lane_fire;
  assign bc_clear  = bc_valid & (&done_nxt);   // last pending lanes accept now

  assign act_ready = w_held & (~bc_valid | bc_clear);
  assign act_fire  = act_valid & act_ready;
  assign w_ready   = ~w_held;
  assign w_fire    = w_valid & w_ready;
  assign last_read = (reads_t'(idx_q) == n_reads_q - reads_t'(1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      n_iters_q <= '0;
      n_reads_q <= '0;
      iter_q    <= '0;
      idx_q     <= '0;
      w_held    <= 1'b0;
      bc_valid  <= 1'b0;
      done      <= '0;
    end else if (configure) begin
      n_iters_q <= num_iters;
      n_reads_q <= num_reads_per_iter;
      iter_q    <= '0;
      idx_q     <= '0;
      w_held    <= 1'b0;
      bc_valid  <= 1'b0;
      done      <= '0;
    end else begin
      if (w_fire) w_held <= 1'b1;
      if (act_fire) begin
        bc_valid <= 1'b1;
        done     <= '0;
        if (last_read) begin
          idx_q  <= '0;
          iter_q <= iter_q + iter_t'(1);
          w_held <= 1'b0;  // next iteration needs a fresh weight word
        end else begin
          idx_q <= idx_q + idx_t'(1);
        end
      end else if (bc_clear) begin
        bc_valid <= 1'b0;
        done     <= '0;
      end else begin
        done <= done_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_fire) w_q <= w_data;
    if (act_fire) begin
      bc_act   <= act_data;
      bc_w     <= w_q;
      bc_idx   <= idx_q;
      bc_first <= (iter_q == '0);
      bc_last  <= (iter_q == n_iters_q - iter_t'(1));
    end
  end

endmodule

`default_nettype wire

// File: kernel_if.sv
//////////////////////////////
// valid/ready streams inside the kernel
// payload stable while valid and not ready
// valid never waits on ready
//////////////////////////////
`default_nettype none

// distributor to lane, one activation group with its weight byte
interface op_if import kernel_pkg::*; ();

  logic   valid;
  logic   ready;
  group_t act;
  data_t  weight;
  idx_t   idx;         // read index inside the iteration
  logic   first_iter;
  logic   last_iter;

  modport src (
    output valid, act, weight, idx, first_iter, last_iter,
    input  ready
  );

  modport dst (
    input  valid, act, weight, idx, first_iter, last_iter,
    output ready
  );

endinterface

// lane to writer, final sums of one read index
interface res_if import kernel_pkg::*; ();

  logic       valid;
  logic       ready;
  acc_group_t sums;
  idx_t       idx;

  modport src (output valid, sums, idx, input ready);
  modport dst (input valid, sums, idx, output ready);

endinterface

`default_nettype wire

// File: kernel_pkg.sv
//////////////////////////////
// widths and types of the inference kernel
// lane count must match the weight word width
// ACC_DEPTH bounds reads per iteration
//////////////////////////////
`default_nettype none

package kernel_pkg;

  localparam int DATA_W     = 8;   // one activation or weight item
  localparam int GROUP_SIZE = 4;   // items per activation word
  localparam int NUM_LANES  = 4;
  localparam int ADDR_W     = 10;
  localparam int ITER_W     = 8;
  localparam int READS_W    = 8;
  localparam int ACC_DEPTH  = 16;  // largest allowed reads per iteration
  localparam int ACC_W      = 2 * DATA_W + ITER_W;  // room for num_iters products

  localparam int IDX_W = $clog2(ACC_DEPTH);
  localparam int CNT_W = ITER_W + READS_W;  // total words one reader may fetch

  typedef logic signed [DATA_W-1:0]          data_t;
  typedef logic [GROUP_SIZE-1:0][DATA_W-1:0] group_t;
  typedef logic [NUM_LANES-1:0][DATA_W-1:0]  weight_word_t;  // byte l feeds lane l
  typedef logic [GROUP_SIZE-1:0][ACC_W-1:0]  acc_group_t;
  typedef logic [ADDR_W-1:0]                 addr_t;
  typedef logic [ITER_W-1:0]                 iter_t;
  typedef logic [READS_W-1:0]                reads_t;
  typedef logic [IDX_W-1:0]                  idx_t;
  typedef logic [CNT_W-1:0]                  count_t;

endpackage

`default_nettype wire

// File: mac_lane.sv
//////////////////////////////
// multiply then accumulate, two stages
// accumulator entry per read index, no reset
// sums leave only in the last iteration
//////////////////////////////
`default_nettype none

module mac_lane import kernel_pkg::*; #(
  parameter int ACC_DEPTH = kernel_pkg::ACC_DEPTH
) (
  input  wire logic clk,
  input  wire logic arst_n,
  op_if.dst         op,
  res_if.src        res
);

  acc_group_t acc_mem [ACC_DEPTH];

  // stage 1, products
  logic       s1_valid;
  logic       s1_first, s1_last;
  idx_t       s1_idx;
  acc_group_t s1_prod;

  // result register towards the writer
  logic       res_valid_q;
  acc_group_t res_sums_q;
  idx_t       res_idx_q;

  acc_group_t prod, sum, acc_rd;
  logic       res_busy, s2_go, op_fire;

  always_comb begin
    logic signed [2*DATA_W-1:0] p;
    for (int g = 0; g < GROUP_SIZE; g++) begin
      p       = $signed(op.act[g]) * op.weight;
      prod[g] = {{(ACC_W-2*DATA_W){p[2*DATA_W-1]}}, p};  // sign extend
    end
  end

  assign acc_rd = acc_mem[s1_idx];

  always_comb begin
    for (int g = 0; g < GROUP_SIZE; g++) begin
      sum[g] = (s1_first ? '0 : acc_rd[g]) + s1_prod[g];
    end
  end

  assign res_busy = res_valid_q & ~res.ready;
  assign s2_go    = s1_valid & ~(s1_last & res_busy);  // only results can stall
  assign op.ready = ~s1_valid | s2_go;
  assign op_fire  = op.valid & op.ready;

  assign res.valid = res_valid_q;
  assign res.sums  = res_sums_q;
  assign res.idx   = res_idx_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid    <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      if (op_fire)    s1_valid <= 1'b1;
      else if (s2_go) s1_valid <= 1'b0;

      if (s2_go && s1_last) res_valid_q <= 1'b1;
      else if (res.ready)   res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (op_fire) begin
      s1_prod  <= prod;
      s1_idx   <= op.idx;
      s1_first <= op.first_iter;
      s1_last  <= op.last_iter;
    end
    if (s2_go && !s1_last) acc_mem[s1_idx] <= sum;
    if (s2_go && s1_last) begin
      res_sums_q <= sum;
      res_idx_q  <= s1_idx;
    end
  end

  // distributor must keep read indices inside the accumulator
  a_idx_range: assert property (@(posedge clk) disable iff (!arst_n)
    op.valid |-> (int'(op.idx) < ACC_DEPTH));

endmodule

`default_nettype wire

// File: mem_reader.sv
//////////////////////////////
// one read outstanding at a time
// memory answers one or more cycles after the request
// count of zero leaves the reader idle
//////////////////////////////
`default_nettype none

module mem_reader import kernel_pkg::*; #(
  parameter int WORD_W = 32
) (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic              configure,
  input  wire count_t            count,      // words to read in this run
  input  wire addr_t             base,
  output addr_t                  mem_addr,
  output logic                   mem_read,
  input  wire logic              mem_valid,
  input  wire logic [WORD_W-1:0] mem_data,
  output logic                   out_valid,
  input  wire logic              out_ready,
  output logic [WORD_W-1:0]      out_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,    // request on the memory port this cycle
    ST_WAIT,   // waiting for the memory answer
    ST_HOLD    // word held until taken downstream
  } state_t;

  state_t state;
  count_t left;   // words not yet passed on

  assign mem_read  = (state == ST_REQ);
  assign out_valid = (state == ST_HOLD);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      left     <= '0;
      mem_addr <= '0;
    end else if (configure) begin
      left     <= count;
      mem_addr <= base;
      state    <= (count != '0) ? ST_REQ : ST_IDLE;
    end else begin
      case (state)
        ST_REQ:  state <= ST_WAIT;
        ST_WAIT: if (mem_valid) state <= ST_HOLD;
        ST_HOLD: begin
          if (out_ready) begin
            left     <= left - count_t'(1);
            mem_addr <= mem_addr + addr_t'(1);
            state    <= (left == count_t'(1)) ? ST_IDLE : ST_REQ;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_WAIT && mem_valid) out_data <= mem_data;
  end

  // memory must not answer a read that was never issued
  a_no_stray_valid: assert property (@(posedge clk) disable iff (!arst_n)
    mem_valid |-> state == ST_WAIT);

endmodule

`default_nettype wire

// File: result_writer.sv
//////////////////////////////
// clips sums to min_clip..max_clip
// one write per accepted word, never busy
// assumes min_clip <= max_clip
//////////////////////////////
`default_nettype none

module result_writer import kernel_pkg::*; (
  input  wire logic  clk,
  input  wire logic  arst_n,
  input  wire logic  configure,
  input  wire addr_t write_address,
  input  wire data_t min_clip,
  input  wire data_t max_clip,
  res_if.dst         res,
  output group_t     data_out,
  output addr_t      addr_out,
  output logic       valid_out
);

  addr_t  base_q;
  data_t  min_q, max_q;
  group_t clip;

  assign res.ready = 1'b1;  // a word is written the cycle after it arrives

  always_comb begin
    logic signed [ACC_W-1:0] s;
    for (int g = 0; g < GROUP_SIZE; g++) begin
      s = $signed(res.sums[g]);
      if (s < min_q)      clip[g] = min_q;
      else if (s > max_q) clip[g] = max_q;
      else                clip[g] = s[DATA_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      base_q    <= '0;
      min_q     <= '0;
      max_q     <= '0;
      valid_out <= 1'b0;
    end else begin
      if (configure) begin
        base_q <= write_address;
        min_q  <= min_clip;
        max_q  <= max_clip;
      end
      valid_out <= res.valid & res.ready;
    end
  end

  always_ff @(posedge clk) begin
    if (res.valid && res.ready) begin
      data_out <= clip;
      addr_out <= base_q + addr_t'(res.idx);
    end
  end

endmodule

`default_nettype wire

// File: rtlinf_kernel.sv
//////////////////////////////
// one inference kernel, broadcast mode
// configure only while idle
// reads per iteration at most ACC_DEPTH
//////////////////////////////
`default_nettype none

module rtlinf_kernel import kernel_pkg::*; #(
  parameter int NUM_LANES = kernel_pkg::NUM_LANES,
  parameter int ACC_DEPTH = kernel_pkg::ACC_DEPTH
) (
  input  wire logic         clk,
  input  wire logic         arst_n,
  input  wire logic         configure,
  input  wire iter_t        num_iters,
  input  wire reads_t       num_reads_per_iter,
  input  wire addr_t        read_address,
  input  wire addr_t        write_address,
  input  wire data_t        min_clip,
  input  wire data_t        max_clip,
  output addr_t             act_addr,
  output logic              act_read,
  input  wire group_t       act_data,
  input  wire logic         act_valid,
  output addr_t             weight_addr,
  output logic              weight_read,
  input  wire weight_word_t weight_data,
  input  wire logic         weight_valid,
  output group_t [NUM_LANES-1:0] data_out,
  output addr_t  [NUM_LANES-1:0] addr_out,
  output logic   [NUM_LANES-1:0] valid_out
);

  logic         rd_act_valid, rd_act_ready;
  group_t       rd_act_data;
  logic         rd_w_valid, rd_w_ready;
  weight_word_t rd_w_data;

  op_if  op_bus  [NUM_LANES] ();
  res_if res_bus [NUM_LANES] ();

  // iterations times reads words, all from read_address upwards
  mem_reader #(.WORD_W($bits(group_t))) u_act_reader (
    .clk, .arst_n, .configure,
    .count     (count_t'(num_iters) * count_t'(num_reads_per_iter)),
    .base      (read_address),
    .mem_addr  (act_addr),
    .mem_read  (act_read),
    .mem_valid (act_valid),
    .mem_data  (act_data),
    .out_valid (rd_act_valid),
    .out_ready (rd_act_ready),
    .out_data  (rd_act_data)
  );

  mem_reader #(.WORD_W($bits(weight_word_t))) u_w_reader (
    .clk, .arst_n, .configure,
    .count     (count_t'(num_iters)),  // one weight word per iteration
    .base      (read_address),
    .mem_addr  (weight_addr),
    .mem_read  (weight_read),
    .mem_valid (weight_valid),
    .mem_data  (weight_data),
    .out_valid (rd_w_valid),
    .out_ready (rd_w_ready),
    .out_data  (rd_w_data)
  );

  distribute_in #(.NUM_LANES(NUM_LANES)) u_dist (
    .clk, .arst_n, .configure, .num_iters, .num_reads_per_iter,
    .act_valid (rd_act_valid),
    .act_ready (rd_act_ready),
    .act_data  (rd_act_data),
    .w_valid   (rd_w_valid),
    .w_ready   (rd_w_ready),
    .w_data    (rd_w_data),
    .lane      (op_bus)
  );

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    mac_lane #(.ACC_DEPTH(ACC_DEPTH)) u_mac (
      .clk, .arst_n,
      .op  (op_bus[l]),
      .res (res_bus[l])
    );

    result_writer u_wr (
      .clk, .arst_n, .configure, .write_address, .min_clip, .max_clip,
      .res       (res_bus[l]),
      .data_out  (data_out[l]),
      .addr_out  (addr_out[l]),
      .valid_out (valid_out[l])
    );
  end

endmodule

`default_nettype wire

// File: sources.f
kernel_pkg.sv
kernel_if.sv
mem_reader.sv
distribute_in.sv
mac_lane.sv
result_writer.sv
rtlinf_kernel.sv
tb_kernel.sv

// File: tb_kernel.sv
//////////////////////////////
// testbench for rtlinf_kernel
// memories filled from a 16-bit LFSR, seed 13
// memory answers 1 to 3 cycles after a read
// tests run back to back, each one a new configure
//////////////////////////////
`default_nettype none

module tb_kernel import kernel_pkg::*; ();

  localparam int N_TESTS = 4;
  localparam int MEM_WORDS = 1 << ADDR_W;

  logic clk = 1'b0;
  logic arst_n, configure;
  iter_t num_iters;
  reads_t num_reads_per_iter;
  addr_t read_address, write_address;
  data_t min_clip, max_clip;
  addr_t act_addr, weight_addr;
  logic act_read, act_valid, weight_read, weight_valid;
  group_t act_data;
  weight_word_t weight_data;
  group_t [NUM_LANES-1:0] data_out;
  addr_t [NUM_LANES-1:0] addr_out;
  logic [NUM_LANES-1:0] valid_out;

  group_t act_mem [MEM_WORDS];
  weight_word_t w_mem [MEM_WORDS];
  group_t exp_q [NUM_LANES][ACC_DEPTH];   // reference results per lane and index
  logic [ACC_DEPTH-1:0] seen [NUM_LANES];
  int wr_cnt [NUM_LANES];

  int t_iters [N_TESTS];
  int t_reads [N_TESTS];
  int t_ra [N_TESTS];
  int t_wa [N_TESTS];
  int t_lo [N_TESTS];
  int t_hi [N_TESTS];

  logic [15:0] lfsr = 16'd13;
  int errors = 0, checks = 0, cycles = 0, limit = 0;
  logic active = 1'b0;                    // a run is configured and not yet checked
  int cur_iters, cur_reads, cur_ra, cur_wa;
  int act_reqs, w_reqs;
  logic act_pend = 1'b0, w_pend = 1'b0;
  int act_cnt, w_cnt;
  addr_t act_req_addr, w_req_addr;

  rtlinf_kernel #(.NUM_LANES(NUM_LANES), .ACC_DEPTH(ACC_DEPTH)) dut0 (.*);

  always #50 clk = ~clk;

  // fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end
    return r;
  endfunction

  task automatic compare_value(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("ERR %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic expect_rule(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("at time %0t the kernel broke a rule: %s", $time, what);
      errors++;
    end
  endtask

  function automatic logic all_written();
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wr_cnt[l] != cur_reads) return 1'b0;
    end
    return 1'b1;
  endfunction

  // sum over iterations of activation item times weight byte, then clip
  task automatic build_expected(input int lo, input int hi);
    int s, av, wv;
    group_t a;
    weight_word_t w;
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int r = 0; r < cur_reads; r++) begin
        for (int g = 0; g < GROUP_SIZE; g++) begin
          s = 0;
          for (int it = 0; it < cur_iters; it++) begin
            a = act_mem[(cur_ra + it * cur_reads + r) % MEM_WORDS];
            w = w_mem[(cur_ra + it) % MEM_WORDS];
            av = $signed(a[g]);
            wv = $signed(w[l]);
            s = s + av * wv;
          end
          if (s < lo) s = lo;
          else if (s > hi) s = hi;
          exp_q[l][r][g] = s[DATA_W-1:0];
        end
      end
    end
  endtask

  task automatic run_test(input int t);
    int err0;
    err0 = errors;
    cur_iters = t_iters[t];
    cur_reads = t_reads[t];
    cur_ra = t_ra[t];
    cur_wa = t_wa[t];
    build_expected(t_lo[t], t_hi[t]);
    act_reqs = 0;
    w_reqs = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      wr_cnt[l] = 0;
      seen[l] = '0;
    end
    @(posedge clk);
    #1;
    active = 1'b1;
    configure = 1'b1;
    num_iters = iter_t'(cur_iters);
    num_reads_per_iter = reads_t'(cur_reads);
    read_address = addr_t'(cur_ra);
    write_address = addr_t'(cur_wa);
    min_clip = data_t'(t_lo[t]);
    max_clip = data_t'(t_hi[t]);
    @(posedge clk);
    #1 configure = 1'b0;
    while (!all_written()) @(negedge clk);
    repeat (3) @(negedge clk);                  // let stray writes show up
    compare_value(act_reqs == cur_iters * cur_reads,
      $sformatf("activation reads %0d, expected %0d", act_reqs, cur_iters * cur_reads));
    compare_value(w_reqs == cur_iters,
      $sformatf("weight reads %0d, expected %0d", w_reqs, cur_iters));
    active = 1'b0;
    $display("test %0d (%0d iters x %0d reads, clip %0d..%0d): %0d errors",
      t, cur_iters, cur_reads, t_lo[t], t_hi[t], errors - err0);
  endtask

  // request side of both memory models, sampled mid cycle
  always @(negedge clk) begin
    if (act_read) begin
      expect_rule(active, "activation read while idle");
      expect_rule(!act_pend, "activation read before the previous answer");
      compare_value(act_addr == addr_t'(cur_ra + act_reqs),
        $sformatf("act_addr %0d, expected %0d", act_addr, cur_ra + act_reqs));
      act_reqs++;
      act_pend = 1'b1;
      act_req_addr = act_addr;
      act_cnt = 1 + take_bits(2) % 3;
    end
    if (weight_read) begin
      expect_rule(active, "weight read while idle");
      expect_rule(!w_pend, "weight read before the previous answer");
      compare_value(weight_addr == addr_t'(cur_ra + w_reqs),
        $sformatf("weight_addr %0d, expected %0d", weight_addr, cur_ra + w_reqs));
      w_reqs++;
      w_pend = 1'b1;
      w_req_addr = weight_addr;
      w_cnt = 1 + take_bits(2) % 3;
    end
  end

  // answer side, driven just after the edge
  always @(posedge clk) begin
    #1;
    act_valid = 1'b0;
    weight_valid = 1'b0;
    if (act_pend) begin
      act_cnt = act_cnt - 1;
      if (act_cnt == 0) begin
        act_valid = 1'b1;
        act_data = act_mem[act_req_addr];
        act_pend = 1'b0;
      end
    end
    if (w_pend) begin
      w_cnt = w_cnt - 1;
      if (w_cnt == 0) begin
        weight_valid = 1'b1;
        weight_data = w_mem[w_req_addr];
        w_pend = 1'b0;
      end
    end
  end

  // write monitor, one check per pulse
  always @(negedge clk) begin
    int idx;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (valid_out[l]) begin
        idx = int'(addr_out[l]) - cur_wa;
        expect_rule(active, $sformatf("lane %0d wrote while idle", l));
        compare_value(idx >= 0 && idx < cur_reads,
          $sformatf("lane %0d addr_out %0d outside the result block", l, addr_out[l]));
        if (idx >= 0 && idx < cur_reads) begin
          expect_rule(!seen[l][idx], $sformatf("lane %0d wrote index %0d twice", l, idx));
          compare_value(data_out[l] == exp_q[l][idx],
            $sformatf("lane %0d idx %0d data %h, expected %h",
              l, idx, data_out[l], exp_q[l][idx]));
          seen[l][idx] = 1'b1;
        end
        wr_cnt[l]++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    arst_n = 1'b0;
    configure = 1'b0;
    num_iters = '0;
    num_reads_per_iter = '0;
    read_address = '0;
    write_address = '0;
    min_clip = '0;
    max_clip = '0;
    act_valid = 1'b0;
    act_data = '0;
    weight_valid = 1'b0;
    weight_data = '0;

    t_iters = '{1, 3, 3, 4};
    t_reads = '{4, 5, 5, 16};
    t_ra = '{0, 40, 80, 500};
    t_wa = '{100, 200, 300, 700};
    t_lo = '{-128, -128, -3, -100};
    t_hi = '{127, 127, 5, 100};
    for (int t = 0; t < N_TESTS; t++) limit += t_iters[t] * t_reads[t] + t_iters[t];
    limit = 8 * limit + 200;

    for (int a = 0; a < MEM_WORDS; a++) begin
      act_mem[a] = take_bits(32);
      w_mem[a] = take_bits(32);
    end

    repeat (16) @(posedge clk);
    #1 arst_n = 1'b1;
    repeat (8) begin                            // idle outputs before any configure
      @(negedge clk);
      expect_rule(!act_read && !weight_read && valid_out == '0,
        "request or write output high before configure");
    end
    $display("idle check after reset: %0d errors", errors);

    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end

    $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
